// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_data_array.sv
      - rtl/dcache_victim_buffer.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/dcache_mem_model.sv
      - bench/dcache_tb.sv

// ==== bench/dcache_mem_model.sv ====
`include "dcache_settings.svh"

module dcache_mem_model (
    input  logic                clk,
    input  logic                resetn,
    input  logic                miss,
    input  dcache_pkg::addr_t   addr,
    input  logic                axi_wvalid,
    input  logic                axi_wlast,
    input  dcache_pkg::addr_t   axi_waddr,
    input  dcache_pkg::word_t   axi_wdata,
    output dcache_pkg::word_t   axi_rdata,
    output logic                axi_rvalid,
    output logic                axi_wready,
    output logic                axi_bvalid
);
    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int LINE_BYTES = `DCACHE_WORDS * 4;

    // sparse storage, untouched words fall back to the fill pattern
    word_t       mem [addr_t];
    int unsigned lcg_state;
    int          rd_count;
    int          wr_count;
    int          bresp_delay;
    addr_t       line_base;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return (a >> 2) + 32'h1000_0000;
    endfunction

    // --------------------
    // responder, one step per falling edge
    // --------------------
    initial begin
        axi_rdata   = '0;
        axi_rvalid  = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        lcg_state   = 83001;
        rd_count    = 0;
        wr_count    = 0;
        bresp_delay = 0;
        forever begin
            @(negedge clk);
            lcg_state  = lcg_next(lcg_state);
            axi_rvalid = 1'b0;
            axi_bvalid = 1'b0;
            if (!resetn) begin
                axi_wready  = 1'b0;
                rd_count    = 0;
                wr_count    = 0;
                bresp_delay = 0;
            end else begin
                // refill words in order, with random gaps
                if (!miss) begin
                    rd_count = 0;
                end else if (rd_count < `DCACHE_WORDS && lcg_state[17:16] != 2'b00) begin
                    line_base  = addr & ~addr_t'(LINE_BYTES - 1);
                    axi_rdata  = read_word(line_base + addr_t'(rd_count * 4));
                    axi_rvalid = 1'b1;
                    rd_count++;
                end
                if (bresp_delay != 0) begin
                    bresp_delay--;
                    if (bresp_delay == 0) begin
                        axi_bvalid = 1'b1;
                    end
                end
                // ready for the coming edge; a word with valid here is taken there
                axi_wready = lcg_state[20];
                if (axi_wvalid && axi_wready) begin
                    mem[axi_waddr + addr_t'(wr_count * 4)] = axi_wdata;
                    wr_count++;
                    if (axi_wlast) begin
                        wr_count    = 0;
                        bresp_delay = 2;
                    end
                end
            end
        end
    end

endmodule

// ==== bench/dcache_tb.sv ====
`include "dcache_settings.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 8;
    localparam int    REQ_LIMIT    = 200;
    localparam string VEC_FILE     = "bench/dcache_vectors.txt";

    logic       clk;
    logic       resetn;
    addr_t      addr;
    logic       addr_ren;
    logic       addr_wen;
    logic [3:0] addr_wsel;
    word_t      addr_wdata;
    word_t      data_o;
    logic       hit;
    logic       wresp;
    word_t      axi_rdata;
    logic       axi_rvalid;
    logic       miss;
    logic       axi_wready;
    logic       axi_bvalid;
    logic       write_back;
    addr_t      axi_waddr;
    word_t      axi_wdata;
    logic       axi_wvalid;
    logic       axi_wlast;

    // vector columns
    byte        op_q    [$];
    addr_t      addr_q  [$];
    logic [3:0] sel_q   [$];
    word_t      wdata_q [$];
    word_t      exp_q   [$];
    bit         hit_q   [$];
    addr_t      wb_q    [$];
    bit         vectors_loaded;

    // expected memory image and accepted write-back words
    word_t      shadow [addr_t];
    word_t      beat_data [$];
    addr_t      beat_addr [$];
    bit         beat_last [$];

    dcache_top dcache_top_i (
        .clk        (clk),
        .resetn     (resetn),
        .addr       (addr),
        .addr_ren   (addr_ren),
        .addr_wen   (addr_wen),
        .addr_wsel  (addr_wsel),
        .addr_wdata (addr_wdata),
        .data_o     (data_o),
        .hit        (hit),
        .wresp      (wresp),
        .axi_rdata  (axi_rdata),
        .axi_rvalid (axi_rvalid),
        .miss       (miss),
        .axi_wready (axi_wready),
        .axi_bvalid (axi_bvalid),
        .write_back (write_back),
        .axi_waddr  (axi_waddr),
        .axi_wdata  (axi_wdata),
        .axi_wvalid (axi_wvalid),
        .axi_wlast  (axi_wlast)
    );

    dcache_mem_model mem_model_i (
        .clk        (clk),
        .resetn     (resetn),
        .miss       (miss),
        .addr       (addr),
        .axi_wvalid (axi_wvalid),
        .axi_wlast  (axi_wlast),
        .axi_waddr  (axi_waddr),
        .axi_wdata  (axi_wdata),
        .axi_rdata  (axi_rdata),
        .axi_rvalid (axi_rvalid),
        .axi_wready (axi_wready),
        .axi_bvalid (axi_bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // reporting and reference helpers
    // --------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else
            fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic ensure(input bit cond, input string what);
        assert (cond) else fail_run(what);
    endtask

    // memory word as the requester last left it
    function automatic word_t memory_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return (a >> 2) + 32'h1000_0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wd,
                                          input logic [3:0] sel);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic load_vectors();
        int         fd;
        int         n;
        string      line;
        byte        op;
        addr_t      a;
        logic [3:0] sel;
        word_t      wd;
        word_t      ex;
        int         cached;
        addr_t      wb;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            fail_run({"could not open the vector file ", VEC_FILE});
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %h %h", op, a, sel, wd, ex, cached, wb);
                if (n != 7) begin
                    fail_run({"malformed vector line: ", line});
                end
                op_q.push_back(op);
                addr_q.push_back(a);
                sel_q.push_back(sel);
                wdata_q.push_back(wd);
                exp_q.push_back(ex);
                hit_q.push_back(cached != 0);
                wb_q.push_back(wb);
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // request driver and checks
    // --------------------
    task automatic run_request(input int i);
        int cycles;
        bit saw_miss;
        bit saw_wb;
        bit is_write;
        cycles   = 0;
        saw_miss = 1'b0;
        saw_wb   = 1'b0;
        is_write = (op_q[i] == "W");
        beat_data.delete();
        beat_addr.delete();
        beat_last.delete();
        // one quiet cycle so the previous pulse is gone
        @(negedge clk);
        addr       = addr_q[i];
        addr_ren   = !is_write;
        addr_wen   = is_write;
        addr_wsel  = sel_q[i];
        addr_wdata = wdata_q[i];
        do begin
            @(negedge clk);
            cycles++;
            if (miss) begin
                saw_miss = 1'b1;
            end
            if (write_back) begin
                saw_wb = 1'b1;
            end
            if (cycles > REQ_LIMIT) begin
                fail_run($sformatf("request %0d to address %h got no response", i, addr_q[i]));
            end
        end while (!hit && !wresp);
        addr_ren = 1'b0;
        addr_wen = 1'b0;

        ensure(is_write ? (wresp && !hit) : (hit && !wresp),
               $sformatf("request %0d was answered with the wrong pulse", i));
        if (!is_write) begin
            compare_value("data_o", data_o, exp_q[i]);
        end
        if (hit_q[i]) begin
            compare_value("response latency", cycles, 2);
            ensure(!saw_miss, $sformatf("request %0d missed but should hit", i));
        end else begin
            ensure(saw_miss, $sformatf("request %0d never raised miss", i));
        end
        if (wb_q[i] != '0) begin
            ensure(saw_wb, $sformatf("request %0d did not write back its victim", i));
            compare_value("write-back words", beat_data.size(), `DCACHE_WORDS);
            for (int k = 0; k < `DCACHE_WORDS; k++) begin
                compare_value("axi_waddr", beat_addr[k], wb_q[i]);
                compare_value("axi_wlast", beat_last[k], k == `DCACHE_WORDS - 1);
                compare_value("axi_wdata", beat_data[k], memory_word(wb_q[i] + addr_t'(4 * k)));
            end
        end else begin
            ensure(!saw_wb && beat_data.size() == 0,
                   $sformatf("request %0d caused a write-back that was not expected", i));
        end
        if (is_write) begin
            shadow[addr_q[i]] = merge_bytes(memory_word(addr_q[i]), wdata_q[i], sel_q[i]);
        end
    endtask

    // words that memory accepts at this edge
    always @(posedge clk) begin
        if (resetn && axi_wvalid && axi_wready) begin
            beat_data.push_back(axi_wdata);
            beat_addr.push_back(axi_waddr);
            beat_last.push_back(axi_wlast);
        end
    end

    initial begin : watchdog
        wait (vectors_loaded);
        #((op_q.size() * REQ_LIMIT + RESET_CYCLES + 4) * CLK_PERIOD);
        fail_run("watchdog expired before the vector list finished");
    end

    initial begin
        resetn         = 1'b0;
        addr           = '0;
        addr_ren       = 1'b0;
        addr_wen       = 1'b0;
        addr_wsel      = '0;
        addr_wdata     = '0;
        vectors_loaded = 1'b0;
        load_vectors();
        vectors_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        compare_value("hit", hit, 0);
        compare_value("wresp", wresp, 0);
        compare_value("miss", miss, 0);
        compare_value("write_back", write_back, 0);
        compare_value("axi_wvalid", axi_wvalid, 0);
        compare_value("axi_wlast", axi_wlast, 0);
        for (int i = 0; i < op_q.size(); i++) begin
            run_request(i);
        end
        if (op_q.size() == 0) begin
            fail_run("the vector file held no operations");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/dcache_vectors.txt ====
# op addr wsel wdata exp_rdata cached wb_addr, all hex
# cached 1: answered from the cache in two cycles; wb_addr 0: no write-back expected

# set 2: clean miss, read hit, byte-masked stores
R 00001044 0 00000000 10000411 0 00000000
R 00001044 0 00000000 10000411 1 00000000
W 00001048 3 aabbccdd 00000000 1 00000000
R 00001048 0 00000000 1000ccdd 1 00000000
W 0000104c c 11223344 00000000 1 00000000
R 0000104c 0 00000000 11220413 1 00000000

# set 2: second tag, made dirty, then the first tag is used again
R 00002040 0 00000000 10000810 0 00000000
W 00002050 1 000000ee 00000000 1 00000000
R 00001040 0 00000000 10000410 1 00000000

# set 2: third tag evicts the older dirty line
R 00003040 0 00000000 10000c10 0 00002040
R 00002050 0 00000000 100008ee 0 00001040
R 00001048 0 00000000 1000ccdd 0 00000000
R 0000104c 0 00000000 11220413 1 00000000

# set 8: write miss, full-word store, eviction and return through memory
W 00005100 f deadbeef 00000000 0 00000000
R 00005100 0 00000000 deadbeef 1 00000000
R 0000511c 0 00000000 10001447 1 00000000
R 00006100 0 00000000 10001840 0 00000000
R 00007104 0 00000000 10001c41 0 00005100
R 00005100 0 00000000 deadbeef 0 00000000
W 00005108 6 12345678 00000000 1 00000000
R 00005108 0 00000000 10345642 1 00000000

// ==== dcache.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_data_array.sv
rtl/dcache_victim_buffer.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

// ==== rtl/dcache_ctrl.sv ====
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  dcache_pkg::addr_t                           addr,
    input  logic                                        addr_ren,
    input  logic                                        addr_wen,
    input  dcache_pkg::byte_en_t                        addr_wsel,
    input  dcache_pkg::word_t                           addr_wdata,
    input  logic                                        axi_rvalid,
    input  dcache_pkg::word_t                           axi_rdata,
    input  logic                                        done,
    input  dcache_pkg::tag_t                            way0_tag,
    input  dcache_pkg::tag_t                            way1_tag,
    input  dcache_pkg::word_t [`DCACHE_WORDS-1:0]       way0_line,
    input  dcache_pkg::word_t [`DCACHE_WORDS-1:0]       way1_line,
    output dcache_pkg::word_t                           data_o,
    output logic                                        hit,
    output logic                                        wresp,
    output logic                                        miss,
    output dcache_pkg::index_t                          index,
    output logic [1:0]                                  tag_wen,
    output dcache_pkg::tag_t                            tag_wdata,
    output dcache_pkg::byte_en_t [`DCACHE_WORDS-1:0]    way0_ben,
    output dcache_pkg::byte_en_t [`DCACHE_WORDS-1:0]    way1_ben,
    output dcache_pkg::word_t                           wdata,
    output logic                                        load,
    output dcache_pkg::tag_t                            victim_tag,
    output dcache_pkg::word_t [`DCACHE_WORDS-1:0]       victim_line
);
    import dcache_pkg::*;

    ctrl_state_t              state;
    logic [`DCACHE_SETS-1:0]  valid [2];
    logic [`DCACHE_SETS-1:0]  dirty [2];
    // lru bit names the way to replace next
    logic [`DCACHE_SETS-1:0]  lru;
    wcount_t                  refill_cnt;

    tag_t    req_tag;
    offset_t req_off;
    logic    hit0;
    logic    hit1;
    logic    lookup_hit;
    logic    hit_way;
    logic    is_write;
    logic    store_hit;
    logic    victim;
    logic    victim_dirty;
    logic    refill_beat;
    logic    refill_last;

    // --------------------
    // address split and compare
    // --------------------
    assign req_tag = addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign index   = addr[`DCACHE_OFFSET_W + `DCACHE_BYTE_OFF_W +: `DCACHE_INDEX_W];
    assign req_off = addr[`DCACHE_BYTE_OFF_W +: `DCACHE_OFFSET_W];

    assign hit0       = valid[0][index] && (way0_tag == req_tag);
    assign hit1       = valid[1][index] && (way1_tag == req_tag);
    assign lookup_hit = hit0 || hit1;
    assign hit_way    = hit1;

    // read wins if both are raised
    assign is_write  = addr_wen && !addr_ren;
    assign store_hit = (state == LOOKUP) && lookup_hit && is_write;

    assign victim       = lru[index];
    assign victim_dirty = valid[victim][index] && dirty[victim][index];

    assign refill_beat = (state == REFILL) && axi_rvalid;
    assign refill_last = refill_beat && (refill_cnt == wcount_t'(`DCACHE_WORDS - 1));

    // --------------------
    // array and buffer side
    // --------------------
    assign miss        = (state == REFILL);
    assign load        = (state == EVICT);
    assign victim_tag  = victim ? way1_tag : way0_tag;
    assign victim_line = victim ? way1_line : way0_line;

    assign wdata     = (state == REFILL) ? axi_rdata : addr_wdata;
    assign tag_wdata = req_tag;
    assign tag_wen   = refill_last ? (victim ? 2'b10 : 2'b01) : 2'b00;

    always_comb begin
        way0_ben = '0;
        way1_ben = '0;
        if (store_hit) begin
            if (hit_way) begin
                way1_ben[req_off] = addr_wsel;
            end else begin
                way0_ben[req_off] = addr_wsel;
            end
        end else if (refill_beat) begin
            // refill words always land whole
            if (victim) begin
                way1_ben[refill_cnt[`DCACHE_OFFSET_W-1:0]] = '1;
            end else begin
                way0_ben[refill_cnt[`DCACHE_OFFSET_W-1:0]] = '1;
            end
        end
    end

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= IDLE;
            hit        <= 1'b0;
            wresp      <= 1'b0;
            valid[0]   <= '0;
            valid[1]   <= '0;
            dirty[0]   <= '0;
            dirty[1]   <= '0;
            lru        <= '0;
            refill_cnt <= '0;
        end else begin
            hit   <= 1'b0;
            wresp <= 1'b0;
            case (state)
                IDLE: begin
                    // request is still up in its answer cycle
                    if ((addr_ren || addr_wen) && !hit && !wresp) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lookup_hit) begin
                        hit        <= !is_write;
                        wresp      <= is_write;
                        lru[index] <= !hit_way;
                        if (is_write) begin
                            dirty[hit_way][index] <= 1'b1;
                        end
                        state <= IDLE;
                    end else if (victim_dirty) begin
                        state <= EVICT;
                    end else begin
                        refill_cnt <= '0;
                        state      <= REFILL;
                    end
                end
                EVICT: begin
                    state <= WAIT_BRESP;
                end
                WAIT_BRESP: begin
                    if (done) begin
                        refill_cnt <= '0;
                        state      <= REFILL;
                    end
                end
                REFILL: begin
                    if (refill_beat) begin
                        refill_cnt <= refill_cnt + 1'b1;
                    end
                    if (refill_last) begin
                        valid[victim][index] <= 1'b1;
                        dirty[victim][index] <= 1'b0;
                        // replay, which now hits
                        state <= LOOKUP;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // hit word for the requester
    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && lookup_hit) begin
            data_o <= hit_way ? way1_line[req_off] : way0_line[req_off];
        end
    end

    // each pulse comes alone and answers the request held in LOOKUP
    a_resp_excl: assert property (@(posedge clk) disable iff (!resetn)
        (hit || wresp) |-> (hit != wresp) && (hit ? $past(addr_ren) : $past(addr_wen)));

    // only a valid dirty line goes to the buffer
    a_load_evict: assert property (@(posedge clk) disable iff (!resetn)
        load |-> victim_dirty);

endmodule

// ==== rtl/dcache_data_array.sv ====
`include "dcache_settings.svh"

module dcache_data_array (
    input  logic                                        clk,
    input  dcache_pkg::index_t                          index,
    input  logic [1:0]                                  tag_wen,
    input  dcache_pkg::tag_t                            tag_wdata,
    input  dcache_pkg::byte_en_t [`DCACHE_WORDS-1:0]    way0_ben,
    input  dcache_pkg::byte_en_t [`DCACHE_WORDS-1:0]    way1_ben,
    input  dcache_pkg::word_t                           wdata,
    output dcache_pkg::tag_t                            way0_tag,
    output dcache_pkg::tag_t                            way1_tag,
    output dcache_pkg::word_t [`DCACHE_WORDS-1:0]       way0_line,
    output dcache_pkg::word_t [`DCACHE_WORDS-1:0]       way1_line
);
    import dcache_pkg::*;

    // byte enables of both ways, way 1 in the upper half
    byte_en_t [1:0][`DCACHE_WORDS-1:0] ben_all;

    assign ben_all = {way1_ben, way0_ben};

    // --------------------
    // per-way storage
    // --------------------
    for (genvar w = 0; w < 2; w++) begin : g_way
        tag_t                      tag_mem  [`DCACHE_SETS];
        word_t                     data_mem [`DCACHE_WORDS][`DCACHE_SETS];
        tag_t                      tag_rd;
        word_t [`DCACHE_WORDS-1:0] line_rd;

        // sync write, one bank per word, byte lanes enabled separately
        always_ff @(posedge clk) begin
            if (tag_wen[w]) begin
                tag_mem[index] <= tag_wdata;
            end
            for (int k = 0; k < `DCACHE_WORDS; k++) begin
                for (int b = 0; b < `DCACHE_BYTES; b++) begin
                    if (ben_all[w][k][b]) begin
                        data_mem[k][index][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end
        end

        // async read of the whole line at index
        assign tag_rd = tag_mem[index];

        for (genvar k = 0; k < `DCACHE_WORDS; k++) begin : g_word
            assign line_rd[k] = data_mem[k][index];
        end
    end

    // --------------------
    // read ports
    // --------------------
    assign way0_tag  = g_way[0].tag_rd;
    assign way1_tag  = g_way[1].tag_rd;
    assign way0_line = g_way[0].line_rd;
    assign way1_line = g_way[1].line_rd;

endmodule

// ==== rtl/dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    // --------------------
    // data and address vectors
    // --------------------
    typedef logic [`DCACHE_WORD_W-1:0]   word_t;
    typedef logic [`DCACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`DCACHE_BYTES-1:0]    byte_en_t;

    // address fields
    typedef logic [`DCACHE_TAG_W-1:0]    tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]  index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    // one extra bit so a full burst of eight fits
    typedef logic [`DCACHE_OFFSET_W:0]   wcount_t;

    // --------------------
    // controller states
    // --------------------
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        WAIT_BRESP,
        REFILL
    } ctrl_state_t;

endpackage

// ==== rtl/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// --------------------
// cache geometry
// --------------------

// two ways, 128 sets, eight words per line
`define DCACHE_SETS      128
`define DCACHE_WORDS     8

// --------------------
// address and data fields
// --------------------

`define DCACHE_ADDR_W    32
`define DCACHE_WORD_W    32
`define DCACHE_BYTES     4

// byte address split: tag | index | word offset | byte offset
`define DCACHE_TAG_W     20
`define DCACHE_INDEX_W   7
`define DCACHE_OFFSET_W  3
`define DCACHE_BYTE_OFF_W 2

`endif

// ==== rtl/dcache_top.sv ====
`include "dcache_settings.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    resetn,
    // requester
    input  dcache_pkg::addr_t       addr,
    input  logic                    addr_ren,
    input  logic                    addr_wen,
    input  dcache_pkg::byte_en_t    addr_wsel,
    input  dcache_pkg::word_t       addr_wdata,
    output dcache_pkg::word_t       data_o,
    output logic                    hit,
    output logic                    wresp,
    // memory read side
    input  dcache_pkg::word_t       axi_rdata,
    input  logic                    axi_rvalid,
    output logic                    miss,
    // memory write side
    input  logic                    axi_wready,
    input  logic                    axi_bvalid,
    output logic                    write_back,
    output dcache_pkg::addr_t       axi_waddr,
    output dcache_pkg::word_t       axi_wdata,
    output logic                    axi_wvalid,
    output logic                    axi_wlast
);
    import dcache_pkg::*;

    index_t                     index;
    logic [1:0]                 tag_wen;
    tag_t                       tag_wdata;
    byte_en_t [`DCACHE_WORDS-1:0] way0_ben;
    byte_en_t [`DCACHE_WORDS-1:0] way1_ben;
    word_t                      wdata;
    tag_t                       way0_tag;
    tag_t                       way1_tag;
    word_t [`DCACHE_WORDS-1:0]  way0_line;
    word_t [`DCACHE_WORDS-1:0]  way1_line;
    logic                       load;
    logic                       done;
    tag_t                       victim_tag;
    word_t [`DCACHE_WORDS-1:0]  victim_line;

    dcache_ctrl ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .addr        (addr),
        .addr_ren    (addr_ren),
        .addr_wen    (addr_wen),
        .addr_wsel   (addr_wsel),
        .addr_wdata  (addr_wdata),
        .axi_rvalid  (axi_rvalid),
        .axi_rdata   (axi_rdata),
        .done        (done),
        .way0_tag    (way0_tag),
        .way1_tag    (way1_tag),
        .way0_line   (way0_line),
        .way1_line   (way1_line),
        .data_o      (data_o),
        .hit         (hit),
        .wresp       (wresp),
        .miss        (miss),
        .index       (index),
        .tag_wen     (tag_wen),
        .tag_wdata   (tag_wdata),
        .way0_ben    (way0_ben),
        .way1_ben    (way1_ben),
        .wdata       (wdata),
        .load        (load),
        .victim_tag  (victim_tag),
        .victim_line (victim_line)
    );

    dcache_data_array data_array_i (
        .clk       (clk),
        .index     (index),
        .tag_wen   (tag_wen),
        .tag_wdata (tag_wdata),
        .way0_ben  (way0_ben),
        .way1_ben  (way1_ben),
        .wdata     (wdata),
        .way0_tag  (way0_tag),
        .way1_tag  (way1_tag),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

    // victim set is the set being looked up
    dcache_victim_buffer victim_buffer_i (
        .clk          (clk),
        .resetn       (resetn),
        .load         (load),
        .victim_tag   (victim_tag),
        .victim_index (index),
        .victim_line  (victim_line),
        .axi_wready   (axi_wready),
        .axi_bvalid   (axi_bvalid),
        .write_back   (write_back),
        .axi_waddr    (axi_waddr),
        .axi_wdata    (axi_wdata),
        .axi_wvalid   (axi_wvalid),
        .axi_wlast    (axi_wlast),
        .done         (done)
    );

endmodule

// ==== rtl/dcache_victim_buffer.sv ====
`include "dcache_settings.svh"

module dcache_victim_buffer (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    load,
    input  dcache_pkg::tag_t                        victim_tag,
    input  dcache_pkg::index_t                      victim_index,
    input  dcache_pkg::word_t [`DCACHE_WORDS-1:0]   victim_line,
    input  logic                                    axi_wready,
    input  logic                                    axi_bvalid,
    output logic                                    write_back,
    output dcache_pkg::addr_t                       axi_waddr,
    output dcache_pkg::word_t                       axi_wdata,
    output logic                                    axi_wvalid,
    output logic                                    axi_wlast,
    output logic                                    done
);
    import dcache_pkg::*;

    word_t [`DCACHE_WORDS-1:0] line_q;
    wcount_t                   wcount;
    offset_t                   next_word;
    logic                      beat;

    // a word leaves on each valid/ready cycle
    assign beat      = axi_wvalid && axi_wready;
    assign next_word = offset_t'(wcount + 1'b1);

    // all eight words sent, response closes the write-back
    assign done = write_back && (wcount == wcount_t'(`DCACHE_WORDS)) && axi_bvalid;

    // --------------------
    // burst control
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            write_back <= 1'b0;
            axi_wvalid <= 1'b0;
            axi_wlast  <= 1'b0;
            wcount     <= '0;
        end else begin
            if (load) begin
                write_back <= 1'b1;
                axi_wvalid <= 1'b1;
                axi_wlast  <= 1'b0;
                wcount     <= '0;
            end else if (beat) begin
                wcount <= wcount + 1'b1;
                if (axi_wlast) begin
                    axi_wvalid <= 1'b0;
                    axi_wlast  <= 1'b0;
                end else begin
                    axi_wlast <= (next_word == offset_t'(`DCACHE_WORDS - 1));
                end
            end else if (done) begin
                write_back <= 1'b0;
            end
        end
    end

    // --------------------
    // line capture and data
    // --------------------
    always_ff @(posedge clk) begin
        if (load) begin
            line_q    <= victim_line;
            axi_waddr <= {victim_tag, victim_index,
                          {(`DCACHE_OFFSET_W + `DCACHE_BYTE_OFF_W){1'b0}}};
            axi_wdata <= victim_line[0];
        end else if (beat && !axi_wlast) begin
            axi_wdata <= line_q[next_word];
        end
    end

    // stalled word holds until memory takes it
    a_w_stable: assert property (@(posedge clk) disable iff (!resetn)
        axi_wvalid && !axi_wready |=>
            axi_wvalid && $stable(axi_wdata) && $stable(axi_wlast));

endmodule
